// ==== ayatsuki_core.f ====
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/reg_file.sv
hdl/decode.sv
hdl/execute.sv
hdl/mem_wb.sv
hdl/ayatsuki_core.sv
sim/core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; exit status is the test result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module core_tb -f ayatsuki_core.f -Mdir obj_dir -o core_tb_sim &&
./obj_dir/core_tb_sim || exit 1

// ==== sim/core_tb.sv ====
// testbench for the core that runs a table of small programs from reset and checks every data store
module core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    localparam word_t      RESET_PC       = 32'h0000_0100;
    localparam int         NUM_PROGS      = 5;
    localparam int         MAX_STORES     = 16;
    localparam int         TIMEOUT_CYCLES = 100 * NUM_PROGS;
    localparam word_t      NOP_WORD       = 32'h0000_0013;
    localparam logic [6:0] OP_IMM_CODE    = 7'b0010011;
    localparam logic [6:0] LOAD_CODE      = 7'b0000011;
    localparam logic [6:0] JALR_CODE      = 7'b1100111;
    localparam logic [6:0] LUI_CODE       = 7'b0110111;
    localparam logic [6:0] AUIPC_CODE     = 7'b0010111;
    localparam logic [6:0] F7_BASE        = 7'b0000000;
    localparam logic [6:0] F7_ALT         = 7'b0100000;

    logic      clk          = 1'b0;
    logic      rst_i        = 1'b1;
    word_t     inst_i       = NOP_WORD;
    word_t     dmem_rdata_i = '0;
    word_t     inst_addr_o;
    dmem_req_t dmem_req_o;

    word_t rom [64];
    word_t ram [64];
    word_t rom_addr;

    // program table and the stores each program must make in order
    word_t progs     [NUM_PROGS][64];
    int    prog_len  [NUM_PROGS];
    word_t exp_addr  [NUM_PROGS][MAX_STORES];
    word_t exp_data  [NUM_PROGS][MAX_STORES];
    int    exp_count [NUM_PROGS];

    int   cur         = 0;
    logic checking    = 1'b0;
    int   stores_seen = 0;
    int   first_store = 0;
    int   store_idx;
    int   cycles      = 0;

    ayatsuki_core #(
        .RESET_PC     (RESET_PC)
    ) DUT (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_i       (inst_i),
        .inst_addr_o  (inst_addr_o),
        .dmem_req_o   (dmem_req_o),
        .dmem_rdata_i (dmem_rdata_i)
    );

    always #50 clk = ~clk;

    // RV32I instruction formats
    function automatic word_t reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                     input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t imm_op(input logic [6:0] opc, input logic [2:0] f3,
                                     input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t store_op(input int rs2, input int rs1, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch_op(input logic [2:0] f3, input int rs1, input int rs2,
                                        input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t upper_op(input logic [6:0] opc, input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic word_t jump_op(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic emit(input int p, input word_t instr);
        progs[p][prog_len[p]] = instr;
        prog_len[p] = prog_len[p] + 1;
    endtask

    task automatic expect_store(input int p, input word_t addr, input word_t data);
        exp_addr[p][exp_count[p]] = addr;
        exp_data[p][exp_count[p]] = data;
        exp_count[p] = exp_count[p] + 1;
    endtask

    task automatic build_programs();
        word_t alu_expect [16];
        for (int p = 0; p < NUM_PROGS; p++) begin
            prog_len[p]  = 0;
            exp_count[p] = 0;
            for (int i = 0; i < 64; i++) begin
                progs[p][i] = NOP_WORD;
            end
        end
        // alu operations on x1 = -7 and x2 = 5 with lui in x3 and auipc in x4
        emit(0, imm_op(OP_IMM_CODE, 3'b000, 1, 0, -7));
        emit(0, imm_op(OP_IMM_CODE, 3'b000, 2, 0, 5));
        emit(0, upper_op(LUI_CODE, 3, 'h12345));
        emit(0, upper_op(AUIPC_CODE, 4, 1));
        emit(0, reg_op(F7_BASE, 3'b000, 5, 1, 2));
        emit(0, reg_op(F7_ALT, 3'b000, 6, 2, 1));
        emit(0, reg_op(F7_BASE, 3'b111, 7, 4, 1));
        emit(0, reg_op(F7_BASE, 3'b110, 8, 3, 2));
        emit(0, reg_op(F7_BASE, 3'b100, 9, 1, 2));
        emit(0, reg_op(F7_BASE, 3'b010, 10, 1, 2));
        emit(0, reg_op(F7_BASE, 3'b011, 11, 1, 2));
        emit(0, reg_op(F7_BASE, 3'b001, 12, 2, 2));
        emit(0, reg_op(F7_BASE, 3'b101, 13, 1, 2));
        emit(0, reg_op(F7_ALT, 3'b101, 14, 1, 2));
        emit(0, imm_op(OP_IMM_CODE, 3'b010, 15, 1, -8));
        emit(0, imm_op(OP_IMM_CODE, 3'b011, 16, 2, 6));
        emit(0, imm_op(OP_IMM_CODE, 3'b100, 17, 3, 'hff));
        emit(0, imm_op(OP_IMM_CODE, 3'b101, 18, 1, 'h401));
        alu_expect = '{32'h1234_5000, RESET_PC + 32'h100C, 32'hFFFF_FFFE, 32'h0000_000C,
                       (RESET_PC + 32'h100C) & 32'hFFFF_FFF9, 32'h1234_5005, 32'hFFFF_FFFC,
                       32'h1, 32'h0, 32'h0000_00A0, 32'h07FF_FFFF, 32'hFFFF_FFFF,
                       32'h0, 32'h1, 32'h1234_50FF, 32'hFFFF_FFFC};
        for (int r = 3; r <= 18; r++) begin
            emit(0, store_op(r, 0, 'h40 + 4 * (r - 3)));
            expect_store(0, 32'h40 + 4 * (r - 3), alu_expect[r - 3]);
        end
        emit(0, jump_op(0, 0));
        // chain of dependent adds
        emit(1, imm_op(OP_IMM_CODE, 3'b000, 1, 0, 3));
        emit(1, reg_op(F7_BASE, 3'b000, 2, 1, 1));
        emit(1, reg_op(F7_BASE, 3'b000, 3, 2, 1));
        emit(1, reg_op(F7_BASE, 3'b000, 4, 3, 2));
        emit(1, reg_op(F7_BASE, 3'b000, 5, 4, 4));
        emit(1, store_op(5, 0, 'h40));
        emit(1, reg_op(F7_BASE, 3'b000, 6, 5, 3));
        emit(1, store_op(6, 0, 'h44));
        emit(1, jump_op(0, 0));
        expect_store(1, 32'h40, 32'd30);
        expect_store(1, 32'h44, 32'd39);
        // store, load back, use at once
        emit(2, upper_op(LUI_CODE, 1, 'hABCDE));
        emit(2, imm_op(OP_IMM_CODE, 3'b000, 1, 1, 'h123));
        emit(2, store_op(1, 0, 'h80));
        emit(2, imm_op(LOAD_CODE, 3'b010, 2, 0, 'h80));
        emit(2, imm_op(OP_IMM_CODE, 3'b000, 3, 2, 1));
        emit(2, store_op(3, 0, 'h84));
        emit(2, imm_op(LOAD_CODE, 3'b010, 4, 0, 'h84));
        emit(2, store_op(4, 0, 'h88));
        emit(2, jump_op(0, 0));
        expect_store(2, 32'h80, 32'hABCD_E123);
        expect_store(2, 32'h84, 32'hABCD_E124);
        expect_store(2, 32'h88, 32'hABCD_E124);
        // x9 holds the poison value that no store may write
        emit(3, imm_op(OP_IMM_CODE, 3'b000, 1, 0, 1));
        emit(3, imm_op(OP_IMM_CODE, 3'b000, 2, 0, 2));
        emit(3, imm_op(OP_IMM_CODE, 3'b000, 3, 0, 3));
        emit(3, imm_op(OP_IMM_CODE, 3'b000, 9, 0, -1));
        emit(3, branch_op(3'b000, 1, 1, 12));
        emit(3, store_op(9, 0, 'h40));
        emit(3, store_op(9, 0, 'h44));
        emit(3, store_op(1, 0, 'h40));
        emit(3, branch_op(3'b100, 9, 1, 12));
        emit(3, store_op(9, 0, 'h44));
        emit(3, store_op(9, 0, 'h48));
        emit(3, store_op(2, 0, 'h44));
        emit(3, branch_op(3'b001, 1, 1, 12));
        emit(3, store_op(3, 0, 'h48));
        emit(3, jump_op(0, 0));
        emit(3, store_op(9, 0, 'h4C));
        expect_store(3, 32'h40, 32'd1);
        expect_store(3, 32'h44, 32'd2);
        expect_store(3, 32'h48, 32'd3);
        // jal and jalr link values and the pc reached through an odd jalr target
        emit(4, jump_op(1, 12));
        emit(4, store_op(0, 0, 'h60));
        emit(4, store_op(0, 0, 'h64));
        emit(4, store_op(1, 0, 'h40));
        emit(4, upper_op(AUIPC_CODE, 6, 0));
        emit(4, imm_op(JALR_CODE, 3'b000, 7, 6, 21));
        emit(4, store_op(0, 0, 'h68));
        emit(4, store_op(0, 0, 'h6C));
        emit(4, store_op(0, 0, 'h70));
        emit(4, store_op(7, 0, 'h44));
        emit(4, upper_op(AUIPC_CODE, 8, 0));
        emit(4, store_op(8, 0, 'h48));
        emit(4, jump_op(0, 0));
        expect_store(4, 32'h40, RESET_PC + 32'd4);
        expect_store(4, 32'h44, RESET_PC + 32'd24);
        expect_store(4, 32'h48, RESET_PC + 32'd40);
    endtask

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_idle();
        assert (!dmem_req_o.we && !dmem_req_o.re && inst_addr_o == RESET_PC)
            else stop_with_error($sformatf(
                "mismatch at %0d ns: reset state wrong, we=%b re=%b inst_addr=%h",
                $time, dmem_req_o.we, dmem_req_o.re, inst_addr_o));
    endtask

    task automatic reset_and_load(input int p);
        @(posedge clk);
        rst_i <= 1'b1;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            if (i == 0) begin
                // core is held from here on
                @(negedge clk);
                for (int a = 0; a < 64; a++) begin
                    rom[a] = progs[p][a];
                end
            end else begin
                check_idle();
            end
        end
        rst_i <= 1'b0;
        @(posedge clk);
        check_idle();
    endtask

    assign rom_addr  = inst_addr_o - RESET_PC;
    assign store_idx = stores_seen - first_store;

    // synchronous instruction ROM
    always @(posedge clk) begin
        inst_i <= rom[rom_addr[7:2]];
    end

    // synchronous data RAM that is cleared while reset is held
    always @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 64; i++) begin
                ram[i] <= '0;
            end
        end else begin
            if (dmem_req_o.we) begin
                ram[dmem_req_o.addr[7:2]] <= dmem_req_o.wdata;
            end
            if (dmem_req_o.re) begin
                dmem_rdata_i <= ram[dmem_req_o.addr[7:2]];
            end
        end
    end

    always @(posedge clk) begin
        if (checking && dmem_req_o.we) begin
            assert (store_idx < exp_count[cur])
                else stop_with_error($sformatf(
                    "mismatch at %0d ns: extra store of %h to %h in program %0d",
                    $time, dmem_req_o.wdata, dmem_req_o.addr, cur));
            assert (dmem_req_o.addr == exp_addr[cur][store_idx]
                    && dmem_req_o.wdata == exp_data[cur][store_idx])
                else stop_with_error($sformatf(
                    "mismatch at %0d ns: program %0d store %0d wrote %h to %h, expected %h to %h",
                    $time, cur, store_idx, dmem_req_o.wdata, dmem_req_o.addr,
                    exp_data[cur][store_idx], exp_addr[cur][store_idx]));
            stores_seen <= stores_seen + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("run timed out after %0d cycles", cycles));
        end
    end

    initial begin
        build_programs();
        for (int p = 0; p < NUM_PROGS; p++) begin
            cur = p;
            reset_and_load(p);
            @(negedge clk);
            first_store = stores_seen;
            checking    = 1'b1;
            while (stores_seen - first_store < exp_count[p]) begin
                @(negedge clk);
            end
            // program now spins on its last jal so nothing more may be stored
            repeat (8) @(negedge clk);
            checking = 1'b0;
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== hdl/ayatsuki_core.sv ====
// top level of the four-stage RV32I core, to be connected to an instruction ROM and a data RAM
module ayatsuki_core #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                rst_i,
    input  core_pkg::word_t     inst_i,
    output core_pkg::word_t     inst_addr_o,
    output core_pkg::dmem_req_t dmem_req_o,
    input  core_pkg::word_t     dmem_rdata_i
);

    import core_pkg::*;

    redirect_t redirect;
    word_t     fd_inst;
    word_t     fd_pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    id_ex_t    id_ex;
    ex_wb_t    ex_wb;
    reg_wr_t   wb;

    fetch_unit #(
        .RESET_PC    (RESET_PC)
    ) u_fetch (
        .clk         (clk),
        .rst_i       (rst_i),
        .redirect_i  (redirect),
        .inst_i      (inst_i),
        .inst_addr_o (inst_addr_o),
        .fd_inst_o   (fd_inst),
        .fd_pc_o     (fd_pc)
    );

    reg_file u_regs (
        .clk         (clk),
        .wr_i        (wb),
        .rs1_addr_i  (rs1_addr),
        .rs2_addr_i  (rs2_addr),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data)
    );

    decode u_decode (
        .clk         (clk),
        .rst_i       (rst_i),
        .redirect_i  (redirect),
        .inst_i      (fd_inst),
        .pc_i        (fd_pc),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .id_ex_o     (id_ex)
    );

    execute u_execute (
        .id_ex_i     (id_ex),
        .wb_i        (wb),
        .redirect_o  (redirect),
        .dmem_req_o  (dmem_req_o),
        .ex_wb_o     (ex_wb)
    );

    mem_wb u_mem_wb (
        .clk          (clk),
        .rst_i        (rst_i),
        .ex_wb_i      (ex_wb),
        .dmem_rdata_i (dmem_rdata_i),
        .wb_o         (wb)
    );

endmodule

// ==== hdl/mem_wb.sv ====
// writeback stage: execute/writeback register and choice between load data and ALU result
module mem_wb (
    input  logic              clk,
    input  logic              rst_i,
    input  core_pkg::ex_wb_t  ex_wb_i,
    input  core_pkg::word_t   dmem_rdata_i,
    output core_pkg::reg_wr_t wb_o
);

    import core_pkg::*;

    ex_wb_t ex_wb_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_wb_q.reg_we <= 1'b0;
            ex_wb_q.load   <= 1'b0;
        end else begin
            ex_wb_q.reg_we <= ex_wb_i.reg_we;
            ex_wb_q.load   <= ex_wb_i.load;
        end
    end

    always_ff @(posedge clk) begin
        ex_wb_q.rd     <= ex_wb_i.rd;
        ex_wb_q.result <= ex_wb_i.result;
    end

    // read data shows up this cycle for a load issued in execute
    assign wb_o.we   = ex_wb_q.reg_we;
    assign wb_o.addr = ex_wb_q.rd;
    assign wb_o.data = ex_wb_q.load ? dmem_rdata_i : ex_wb_q.result;

endmodule

// ==== hdl/execute.sv ====
// execute stage: operand forwarding, ALU, jump resolution and data memory request
module execute (
    input  core_pkg::id_ex_t    id_ex_i,
    input  core_pkg::reg_wr_t   wb_i,
    output core_pkg::redirect_t redirect_o,
    output core_pkg::dmem_req_t dmem_req_o,
    output core_pkg::ex_wb_t    ex_wb_o
);

    import core_pkg::*;

    word_t rs1_f;
    word_t rs2_f;
    word_t alu_a;
    word_t alu_b;
    word_t alu_res;
    word_t mem_addr;
    word_t link;
    logic  is_jump;
    logic  cond;

    function automatic word_t fwd(reg_addr_t idx, word_t captured, reg_wr_t wb);
        if (wb.we && wb.addr == idx && idx != 5'd0) begin
            return wb.data;
        end
        return captured;
    endfunction

    assign rs1_f = fwd(id_ex_i.rs1_addr, id_ex_i.rs1_data, wb_i);
    assign rs2_f = fwd(id_ex_i.rs2_addr, id_ex_i.rs2_data, wb_i);

    assign alu_a = id_ex_i.use_pc ? id_ex_i.pc : rs1_f;
    assign alu_b = id_ex_i.use_imm ? id_ex_i.imm : rs2_f;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_SUB:    alu_res = alu_a - alu_b;
            ALU_AND:    alu_res = alu_a & alu_b;
            ALU_OR:     alu_res = alu_a | alu_b;
            ALU_XOR:    alu_res = alu_a ^ alu_b;
            ALU_SLT:    alu_res = {31'd0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU:   alu_res = {31'd0, alu_a < alu_b};
            ALU_SLL:    alu_res = alu_a << alu_b[4:0];
            ALU_SRL:    alu_res = alu_a >> alu_b[4:0];
            ALU_SRA:    alu_res = word_t'($signed(alu_a) >>> alu_b[4:0]);
            ALU_PASS_B: alu_res = alu_b;
            default:    alu_res = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (id_ex_i.branch)
            BR_BEQ:           cond = (rs1_f == rs2_f);
            BR_BNE:           cond = (rs1_f != rs2_f);
            BR_BLT:           cond = ($signed(rs1_f) < $signed(rs2_f));
            BR_BGE:           cond = ($signed(rs1_f) >= $signed(rs2_f));
            BR_JAL, BR_JALR:  cond = 1'b1;
            default:          cond = 1'b0;
        endcase
    end

    // shared by loads, stores and jalr
    assign mem_addr = rs1_f + id_ex_i.imm;
    assign link     = id_ex_i.pc + 32'd4;
    assign is_jump  = (id_ex_i.branch == BR_JAL) || (id_ex_i.branch == BR_JALR);

    assign redirect_o.taken  = id_ex_i.valid && cond;
    assign redirect_o.target = (id_ex_i.branch == BR_JALR) ? {mem_addr[31:1], 1'b0}
                                                           : id_ex_i.pc + id_ex_i.imm;

    // read goes out now so the block RAM answers in writeback
    assign dmem_req_o.we    = id_ex_i.valid && id_ex_i.store;
    assign dmem_req_o.re    = id_ex_i.valid && id_ex_i.load;
    assign dmem_req_o.addr  = mem_addr;
    assign dmem_req_o.wdata = rs2_f;

    assign ex_wb_o.reg_we = id_ex_i.valid && id_ex_i.reg_we;
    assign ex_wb_o.load   = id_ex_i.valid && id_ex_i.load;
    assign ex_wb_o.rd     = id_ex_i.rd;
    assign ex_wb_o.result = is_jump ? link : alu_res;

endmodule

// ==== hdl/decode.sv ====
// decode stage: field split, immediates, control flags and the decode/execute register
module decode (
    input  logic                clk,
    input  logic                rst_i,
    input  core_pkg::redirect_t redirect_i,
    input  core_pkg::word_t     inst_i,
    input  core_pkg::word_t     pc_i,
    output core_pkg::reg_addr_t rs1_addr_o,
    output core_pkg::reg_addr_t rs2_addr_o,
    input  core_pkg::word_t     rs1_data_i,
    input  core_pkg::word_t     rs2_data_i,
    output core_pkg::id_ex_t    id_ex_o
);

    import core_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    id_ex_t     dec;

    assign opcode     = opcode_e'(inst_i[6:0]);
    assign funct3     = inst_i[14:12];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'd0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // alt selects sub / sra
    function automatic alu_op_e alu_sel(logic [2:0] f3, logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        dec          = '0;
        dec.valid    = 1'b1;
        dec.pc       = pc_i;
        dec.rs1_addr = rs1_addr_o;
        dec.rs2_addr = rs2_addr_o;
        dec.rs1_data = rs1_data_i;
        dec.rs2_data = rs2_data_i;
        dec.rd       = inst_i[11:7];
        dec.alu_op   = ALU_ADD;
        dec.branch   = BR_NONE;
        case (opcode)
            OPC_OP: begin
                dec.alu_op = alu_sel(funct3, inst_i[30]);
                dec.reg_we = 1'b1;
            end
            OPC_OP_IMM: begin
                // immediate form has no subi, only srai uses bit 30
                dec.alu_op  = alu_sel(funct3, inst_i[30] && funct3 == 3'b101);
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                dec.reg_we  = 1'b1;
            end
            OPC_LUI: begin
                dec.alu_op  = ALU_PASS_B;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.reg_we  = 1'b1;
            end
            OPC_AUIPC: begin
                dec.use_pc  = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.reg_we  = 1'b1;
            end
            OPC_LOAD: begin
                dec.imm    = imm_i;
                dec.load   = (funct3 == 3'b010);
                dec.reg_we = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                dec.imm   = imm_s;
                dec.store = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                dec.imm = imm_b;
                case (funct3)
                    3'b000:  dec.branch = BR_BEQ;
                    3'b001:  dec.branch = BR_BNE;
                    3'b100:  dec.branch = BR_BLT;
                    3'b101:  dec.branch = BR_BGE;
                    default: dec.branch = BR_NONE;
                endcase
            end
            OPC_JAL: begin
                dec.imm    = imm_j;
                dec.branch = BR_JAL;
                dec.reg_we = 1'b1;
            end
            OPC_JALR: begin
                dec.imm    = imm_i;
                dec.branch = BR_JALR;
                dec.reg_we = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i || redirect_i.taken) begin
            id_ex_o.valid <= 1'b0;
        end else begin
            id_ex_o <= dec;
        end
    end

endmodule

// ==== hdl/reg_file.sv ====
// integer register file, two read ports and one write port fed from writeback
module reg_file (
    input  logic                clk,
    input  core_pkg::reg_wr_t   wr_i,
    input  core_pkg::reg_addr_t rs1_addr_i,
    input  core_pkg::reg_addr_t rs2_addr_i,
    output core_pkg::word_t     rs1_data_o,
    output core_pkg::word_t     rs2_data_o
);

    import core_pkg::*;

    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (wr_i.we && wr_i.addr != 5'd0) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    function automatic word_t read_port(reg_addr_t idx, reg_wr_t wr);
        if (idx == 5'd0) begin
            return 32'd0;
        end
        // write-first so decode sees the value landing this cycle
        if (wr.we && wr.addr == idx) begin
            return wr.data;
        end
        return regs[idx];
    endfunction

    assign rs1_data_o = read_port(rs1_addr_i, wr_i);
    assign rs2_data_o = read_port(rs2_addr_i, wr_i);

endmodule

// ==== hdl/fetch_unit.sv ====
// fetch stage: pc register, instruction address to the ROM, and pc/instruction pair for decode
module fetch_unit #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                rst_i,
    input  core_pkg::redirect_t redirect_i,
    input  core_pkg::word_t     inst_i,
    output core_pkg::word_t     inst_addr_o,
    output core_pkg::word_t     fd_inst_o,
    output core_pkg::word_t     fd_pc_o
);

    import core_pkg::*;

    word_t pc;
    word_t pc_q;
    logic  kill_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc     <= RESET_PC;
            kill_q <= 1'b1;
        end else begin
            // slot arriving after a redirect belongs to the wrong path
            kill_q <= redirect_i.taken;
            if (redirect_i.taken) begin
                pc <= redirect_i.target;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    // address of the word the ROM returns this cycle
    always_ff @(posedge clk) begin
        pc_q <= pc;
    end

    assign inst_addr_o = pc;
    assign fd_pc_o     = pc_q;
    assign fd_inst_o   = kill_q ? NOP_INSTR : inst_i;

endmodule

// ==== hdl/core_pkg.sv ====
// shared widths, opcode/ALU/jump enums and pipeline structs, imported by every core module
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // RV32I major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_JAL, BR_JALR
    } branch_e;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } reg_wr_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        alu_op_e   alu_op;
        branch_e   branch;
        logic      use_imm;
        logic      use_pc;
        logic      load;
        logic      store;
        logic      reg_we;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        logic      reg_we;
        logic      load;
        reg_addr_t rd;
        word_t     result;
    } ex_wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic  we;
        logic  re;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage
